// File: rtl/cpc_ram_pkg.sv
// ##########################################################
// RAM expansion shared types. Block schemes, cycle states
// and the field widths of the bank and SRAM address
// ##########################################################
`default_nettype none

package cpc_ram_pkg;

  // Width of the ccc bank field in the bank-select byte
  localparam int bank_w = 3;

  // Width of the SRAM high address: bank then block
  localparam int ramadr_w = 5;

  // The shadow bank is always one of banks 3 or 7
  // The top bit comes from a DIP switch latched in reset
  localparam logic [1:0] shadow_low_bits = 2'b11;

  // Block-switching schemes selected by the bbb field
  // The encodings are the raw bbb values written by the CPU
  typedef enum logic [2:0] {
    scheme_internal   = 3'd0,
    scheme_top_block  = 3'd1,
    scheme_all_blocks = 3'd2,
    scheme_c3         = 3'd3,
    // The window schemes put one block at 0x4000-0x7FFF
    scheme_win0       = 3'd4,
    scheme_win1       = 3'd5,
    scheme_win2       = 3'd6,
    scheme_win3       = 3'd7
  } map_scheme_e;

  // Kind of CPU memory cycle in progress
  // Refresh and cycles not yet classified stay idle
  typedef enum logic [1:0] {
    cyc_idle  = 2'd0,
    cyc_read  = 2'd1,
    cyc_write = 2'd2
  } cycle_state_e;

endpackage

`default_nettype wire

// File: rtl/bank_reg_decode.sv
// ##########################################################
// Bank-select port decode. Holds bank, scheme, card select
// and the DIP configuration latches
// ##########################################################
`timescale 1ns/1ps
`default_nettype none

module bank_reg_decode import cpc_ram_pkg::*; (
  input  wire                     clk,
  input  wire                     reset_b_w,
  input  wire                     iorq_b,
  input  wire                     wr_b,
  input  wire                     adr15,
  input  wire                     adr8,
  input  wire [7:0]               data,
  input  wire [3:0]               dip,
  output logic [bank_w-1:0]       bank,
  output map_scheme_e             scheme,
  output logic                    card_sel,
  output logic                    mode3,
  output logic                    shadow_mode,
  output logic                    full_shadow,
  output logic                    overdrive_mode,
  output logic [bank_w-1:0]       shadow_bank
);

  logic dip2_lat;
  logic dip3_lat;
  logic port_match;
  logic select_write;

  // Static DIP options, read live
  // Any shadow mode also needs the 464 RD/WR overdrive
  assign overdrive_mode = dip[0] | dip[1];
  assign shadow_mode    = dip[0];
  assign full_shadow    = dip[0] & dip[1];

  // dip3 picks bank 7 rather than bank 3 as the shadow bank
  assign shadow_bank = {dip3_lat, shadow_low_bits};

  // dip2 moves the card from port 0x7Fxx to 0x7Exx
  assign port_match = dip2_lat ? !adr8 : adr8;

  // IO write with A15 low and data 0b11xxxxx on our port
  assign select_write = !iorq_b && !wr_b && !adr15 && (data[7:6] == 2'b11) && port_match;

  // The config switches share pins with the SRAM address
  // They are only sampled while the system sits in reset
  always_ff @(posedge clk) begin
    if (!reset_b_w) begin
      dip2_lat <= dip[2];
      dip3_lat <= dip[3];
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_b_w) begin
      bank     <= '0;
      scheme   <= scheme_internal;
      card_sel <= 1'b0;
      mode3    <= 1'b0;
    end else if (select_write) begin
      // Alias the shadow bank away by clearing its middle bit
      // so the CPU can never map over the shadow copy
      if (shadow_mode && (data[5:3] == shadow_bank)) begin
        bank <= {data[5], 1'b0, data[3]};
      end else begin
        bank <= data[5:3];
      end
      scheme   <= map_scheme_e'(data[2:0]);
      card_sel <= 1'b1;
      // Pre-decoded so the A15 overdrive path stays short
      mode3    <= (data[2:0] == scheme_c3);
    end
  end

endmodule

`default_nettype wire

// File: rtl/mem_cycle_track.sv
// ##########################################################
// Memory cycle tracker. Classifies each MREQ cycle as read
// or write and captures A15 at the start of the cycle
// ##########################################################
`timescale 1ns/1ps
`default_nettype none

module mem_cycle_track import cpc_ram_pkg::*; (
  input  wire          clk,
  input  wire          reset_b_w,
  input  wire          mreq_b,
  input  wire          rfsh_b,
  input  wire          rd_b,
  input  wire          m1_b,
  input  wire          adr15,
  output cycle_state_e cyc_state,
  output logic         mreq_fall,
  output logic         adr15_cyc
);

  logic mreq_b_q;

  // MREQ was high last edge and is low now
  assign mreq_fall = mreq_b_q & !mreq_b;

  always_ff @(posedge clk) begin
    if (!reset_b_w) begin
      mreq_b_q <= 1'b1;
    end else begin
      mreq_b_q <= mreq_b;
    end
  end

  // State is set once at the start of the cycle and held
  // until MREQ goes high again
  always_ff @(posedge clk) begin
    if (!reset_b_w) begin
      cyc_state <= cyc_idle;
    end else if (mreq_b) begin
      cyc_state <= cyc_idle;
    end else if (mreq_fall) begin
      // RD still high at the start of a non-M1, non-refresh cycle
      // means WR will follow later
      if (rfsh_b && rd_b && m1_b) begin
        cyc_state <= cyc_write;
      end else if (!rd_b) begin
        cyc_state <= cyc_read;
      end
    end
  end

  // The C3 scheme overdrives A15 mid-cycle
  // Decode must use the value the CPU put out at the start
  always_ff @(posedge clk) begin
    if (!reset_b_w) begin
      adr15_cyc <= 1'b0;
    end else if (mreq_fall) begin
      adr15_cyc <= adr15;
    end
  end

endmodule

`default_nettype wire

// File: rtl/block_map.sv
// ##########################################################
// Block mapper. Turns bank, scheme and address quadrant into
// an expansion hit and the SRAM high address
// ##########################################################
`timescale 1ns/1ps
`default_nettype none

module block_map import cpc_ram_pkg::*; (
  input  wire [bank_w-1:0]    bank,
  input  map_scheme_e         scheme,
  input  wire                 shadow_mode,
  input  wire [bank_w-1:0]    shadow_bank,
  input  wire                 adr15,
  input  wire                 adr14,
  input  wire                 adr15_cyc,
  input  cycle_state_e        cyc_state,
  output logic                exp_hit,
  output logic                ram_sel,
  output logic [ramadr_w-1:0] ram_adr
);

  logic [1:0] quad;
  logic [1:0] quad_c3;
  logic [2:0] scheme_bits;
  logic [1:0] win_block;
  logic       shadow_write;

  assign quad    = {adr15, adr14};
  // A15 may be overdriven in C3 so use the start-of-cycle copy
  assign quad_c3 = {adr15_cyc, adr14};

  // The low two scheme bits of the window schemes name the block
  assign scheme_bits = scheme;
  assign win_block   = scheme_bits[1:0];

  // In shadow mode every write that misses still lands in the
  // shadow bank so the copy tracks internal RAM
  assign shadow_write = shadow_mode && (cyc_state == cyc_write);

  always_comb begin
    // Miss by default
    exp_hit = 1'b0;
    ram_sel = shadow_write;
    ram_adr = {shadow_bank, quad};

    case (scheme)
      scheme_top_block: begin
        if (quad == 2'b11) begin
          exp_hit = 1'b1;
          ram_adr = {bank, 2'b11};
        end
      end
      scheme_all_blocks: begin
        exp_hit = 1'b1;
        ram_adr = {bank, quad};
      end
      scheme_c3: begin
        if (quad_c3 == 2'b11) begin
          exp_hit = 1'b1;
          ram_adr = {bank, 2'b11};
        end else if (shadow_mode && (quad_c3 == 2'b01)) begin
          // Shadow copy of block 3 seen through the 0x4000 window
          ram_sel = 1'b1;
          ram_adr = {shadow_bank, 2'b11};
        end
      end
      scheme_win0, scheme_win1, scheme_win2, scheme_win3: begin
        if (quad == 2'b01) begin
          exp_hit = 1'b1;
          ram_adr = {bank, win_block};
        end
      end
      default: begin
        // scheme_internal keeps the miss result
        exp_hit = 1'b0;
      end
    endcase

    // Any hit selects the SRAM
    if (exp_hit) begin
      ram_sel = 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: rtl/ram_strobe_drive.sv
// ##########################################################
// SRAM strobe and bus overdrive logic. Chip select, RAMDIS
// and the A15, RD and WR pull levels and enables
// ##########################################################
`timescale 1ns/1ps
`default_nettype none

module ram_strobe_drive import cpc_ram_pkg::*; (
  input  wire                 clk,
  input  wire                 reset_b_w,
  input  wire                 card_sel,
  input  wire                 full_shadow,
  input  wire                 overdrive_mode,
  input  wire                 shadow_mode,
  input  wire                 mode3,
  input  wire                 exp_hit,
  input  wire                 ram_sel,
  input  wire [ramadr_w-1:0]  ram_adr,
  input  cycle_state_e        cyc_state,
  input  wire                 mreq_fall,
  input  wire                 mreq_b,
  input  wire                 rfsh_b,
  input  wire                 adr14,
  input  wire                 wr_b,
  input  wire                 ramrd_b,
  output logic                ramcs_b,
  output logic                ramoe_b,
  output logic                ramwe_b,
  output logic [4:0]          ramadrhi,
  output logic                ramadrhi_oe,
  output logic                ramdis,
  output logic                ramdis_oe,
  output logic                adr15_drive,
  output logic                adr15_oe,
  output logic                rd_drive,
  output logic                rd_oe,
  output logic                wr_drive,
  output logic                wr_oe
);

  logic write_seen_q;
  logic write_cyc;
  logic write_first;
  logic card_hit;
  logic write_start;
  logic a15_window;

  assign write_cyc   = (cyc_state == cyc_write);
  // High only until the edge after the write was classified
  assign write_first = write_cyc & !write_seen_q;
  assign card_hit    = card_sel & ram_sel;

  always_ff @(posedge clk) begin
    if (!reset_b_w) begin
      write_seen_q <= 1'b0;
    end else begin
      write_seen_q <= write_cyc;
    end
  end

  // Full shadow serves every real memory cycle from the SRAM
  // RAMRD on the OE pin keeps ROM reads off the data bus
  assign ramcs_b = !((card_hit | full_shadow) & !mreq_b & rfsh_b);
  assign ramoe_b = ramrd_b;
  assign ramwe_b = wr_b;

  // The high address pins carry the DIP switches during reset
  assign ramadrhi    = ram_adr;
  assign ramadrhi_oe = reset_b_w;

  assign ramdis_oe = reset_b_w & (full_shadow | card_hit);
  assign ramdis    = ramdis_oe;

  // A write looks like a cycle with no RAM read at its first edge
  // The gate array must see A15 before the state register sets
  assign write_start = mreq_fall & rfsh_b & ramrd_b;
  assign a15_window  = shadow_mode ? (write_cyc | write_start) : !mreq_b;

  // C3 remaps 0x4000 accesses to 0xC000 by forcing A15 high
  assign adr15_oe    = reset_b_w & overdrive_mode & mode3 & adr14 & rfsh_b & a15_window;
  assign adr15_drive = adr15_oe;

  // 464 machines need RD held low for the whole expansion write
  assign rd_oe    = reset_b_w & overdrive_mode & exp_hit & write_cyc;
  assign rd_drive = !rd_oe;

  // WR is pulled low early, but only for one clock
  assign wr_oe    = reset_b_w & overdrive_mode & exp_hit & write_first;
  assign wr_drive = !wr_oe;

endmodule

`default_nettype wire

// File: rtl/ram512k_ctrl.sv
// ##########################################################
// 512K RAM expansion controller top level
// ##########################################################
`timescale 1ns/1ps
`default_nettype none

module ram512k_ctrl import cpc_ram_pkg::*; (
  input  wire       clk,
  input  wire       reset_b_w,
  input  wire       adr15,
  input  wire       adr14,
  input  wire       adr8,
  input  wire       iorq_b,
  input  wire       mreq_b,
  input  wire       rfsh_b,
  input  wire       m1_b,
  input  wire       rd_b,
  input  wire       wr_b,
  input  wire       ramrd_b,
  input  wire [7:0] data,
  input  wire [3:0] dip,
  output logic      ramcs_b,
  output logic      ramoe_b,
  output logic      ramwe_b,
  output logic [4:0] ramadrhi,
  output logic      ramadrhi_oe,
  output logic      ramdis,
  output logic      ramdis_oe,
  output logic      adr15_drive,
  output logic      adr15_oe,
  output logic      rd_drive,
  output logic      rd_oe,
  output logic      wr_drive,
  output logic      wr_oe
);

  logic [bank_w-1:0]   bank;
  map_scheme_e         scheme;
  logic                card_sel;
  logic                mode3;
  logic                shadow_mode;
  logic                full_shadow;
  logic                overdrive_mode;
  logic [bank_w-1:0]   shadow_bank;
  cycle_state_e        cyc_state;
  logic                mreq_fall;
  logic                adr15_cyc;
  logic                exp_hit;
  logic                ram_sel;
  logic [ramadr_w-1:0] ram_adr;

  // Decode of the bank-select port
  bank_reg_decode u_decode (
    .clk            (clk),
    .reset_b_w      (reset_b_w),
    .iorq_b         (iorq_b),
    .wr_b           (wr_b),
    .adr15          (adr15),
    .adr8           (adr8),
    .data           (data),
    .dip            (dip),
    .bank           (bank),
    .scheme         (scheme),
    .card_sel       (card_sel),
    .mode3          (mode3),
    .shadow_mode    (shadow_mode),
    .full_shadow    (full_shadow),
    .overdrive_mode (overdrive_mode),
    .shadow_bank    (shadow_bank)
  );

  mem_cycle_track u_cycle (
    .clk       (clk),
    .reset_b_w (reset_b_w),
    .mreq_b    (mreq_b),
    .rfsh_b    (rfsh_b),
    .rd_b      (rd_b),
    .m1_b      (m1_b),
    .adr15     (adr15),
    .cyc_state (cyc_state),
    .mreq_fall (mreq_fall),
    .adr15_cyc (adr15_cyc)
  );

  // Execute stage, purely combinational
  block_map u_map (
    .bank        (bank),
    .scheme      (scheme),
    .shadow_mode (shadow_mode),
    .shadow_bank (shadow_bank),
    .adr15       (adr15),
    .adr14       (adr14),
    .adr15_cyc   (adr15_cyc),
    .cyc_state   (cyc_state),
    .exp_hit     (exp_hit),
    .ram_sel     (ram_sel),
    .ram_adr     (ram_adr)
  );

  ram_strobe_drive u_drive (
    .clk            (clk),
    .reset_b_w      (reset_b_w),
    .card_sel       (card_sel),
    .full_shadow    (full_shadow),
    .overdrive_mode (overdrive_mode),
    .shadow_mode    (shadow_mode),
    .mode3          (mode3),
    .exp_hit        (exp_hit),
    .ram_sel        (ram_sel),
    .ram_adr        (ram_adr),
    .cyc_state      (cyc_state),
    .mreq_fall      (mreq_fall),
    .mreq_b         (mreq_b),
    .rfsh_b         (rfsh_b),
    .adr14          (adr14),
    .wr_b           (wr_b),
    .ramrd_b        (ramrd_b),
    .ramcs_b        (ramcs_b),
    .ramoe_b        (ramoe_b),
    .ramwe_b        (ramwe_b),
    .ramadrhi       (ramadrhi),
    .ramadrhi_oe    (ramadrhi_oe),
    .ramdis         (ramdis),
    .ramdis_oe      (ramdis_oe),
    .adr15_drive    (adr15_drive),
    .adr15_oe       (adr15_oe),
    .rd_drive       (rd_drive),
    .rd_oe          (rd_oe),
    .wr_drive       (wr_drive),
    .wr_oe          (wr_oe)
  );

endmodule

`default_nettype wire

// File: bench/ram512k_ctrl_sva.sv
// ##########################################################
// Bound assertions on the SRAM strobe and bus drive outputs
// ##########################################################
`timescale 1ns/1ps
`default_nettype none

module ram512k_ctrl_sva (
  input wire clk,
  input wire reset_b_w,
  input wire rfsh_b,
  input wire ramcs_b,
  input wire ramadrhi_oe,
  input wire ramdis_oe,
  input wire adr15_oe,
  input wire rd_oe,
  input wire wr_oe
);

  // The pads must stay released while the DIP switches are read
  a_quiet_in_reset: assert property (@(posedge clk)
    !reset_b_w |-> !(ramadrhi_oe | ramdis_oe | adr15_oe | rd_oe | wr_oe))
    else $error("bus drive enable set while reset is low");

  // The early WR pull is a single clock pulse
  a_wr_pulse: assert property (@(posedge clk) disable iff (!reset_b_w)
    wr_oe |=> !wr_oe)
    else $error("wr_oe held for more than one cycle");

  // Refresh cycles never reach the SRAM
  a_no_refresh_cs: assert property (@(posedge clk)
    !rfsh_b |-> ramcs_b)
    else $error("ramcs_b low during a refresh cycle");

endmodule

bind ram_strobe_drive ram512k_ctrl_sva sva0 (
  .clk         (clk),
  .reset_b_w   (reset_b_w),
  .rfsh_b      (rfsh_b),
  .ramcs_b     (ramcs_b),
  .ramadrhi_oe (ramadrhi_oe),
  .ramdis_oe   (ramdis_oe),
  .adr15_oe    (adr15_oe),
  .rd_oe       (rd_oe),
  .wr_oe       (wr_oe)
);

`default_nettype wire

// File: bench/ram512k_ctrl_tb.sv
// ##########################################################
// Testbench for the 512K RAM expansion controller. Replays
// bus transactions from a stimulus file and checks outputs
// ##########################################################
`timescale 1ns/1ps
`default_nettype none

module ram512k_ctrl_tb;

  localparam int max_lines    = 64;
  localparam int reset_cycles = 10;

  logic       clk;
  logic       reset_b_w;
  logic       adr15;
  logic       adr14;
  logic       adr8;
  logic       iorq_b;
  logic       mreq_b;
  logic       rfsh_b;
  logic       m1_b;
  logic       rd_b;
  logic       wr_b;
  logic       ramrd_b;
  logic [7:0] data;
  logic [3:0] dip;
  logic       ramcs_b;
  logic       ramoe_b;
  logic       ramwe_b;
  logic [4:0] ramadrhi;
  logic       ramadrhi_oe;
  logic       ramdis;
  logic       ramdis_oe;
  logic       adr15_drive;
  logic       adr15_oe;
  logic       rd_drive;
  logic       rd_oe;
  logic       wr_drive;
  logic       wr_oe;

  // One row per transaction, twelve hex columns as in the file
  logic [7:0] stim [max_lines][12];
  int         line_count  = 0;
  int         cycle_count = 0;
  int         cycle_limit = 0;

  ram512k_ctrl dut0 (
    .clk (clk), .reset_b_w (reset_b_w), .adr15 (adr15), .adr14 (adr14),
    .adr8 (adr8), .iorq_b (iorq_b), .mreq_b (mreq_b), .rfsh_b (rfsh_b),
    .m1_b (m1_b), .rd_b (rd_b), .wr_b (wr_b), .ramrd_b (ramrd_b),
    .data (data), .dip (dip), .ramcs_b (ramcs_b), .ramoe_b (ramoe_b),
    .ramwe_b (ramwe_b), .ramadrhi (ramadrhi), .ramadrhi_oe (ramadrhi_oe),
    .ramdis (ramdis), .ramdis_oe (ramdis_oe), .adr15_drive (adr15_drive),
    .adr15_oe (adr15_oe), .rd_drive (rd_drive), .rd_oe (rd_oe),
    .wr_drive (wr_drive), .wr_oe (wr_oe)
  );

  always #4 clk = ~clk;

  // Every transaction fits well inside twenty clocks
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_limit != 0 && cycle_count > cycle_limit) begin
      $display("CHECKS FAILED");
      $fatal(1, "timeout, the stimulus did not finish in %0d clock cycles", cycle_limit);
    end
  end

  task automatic load_stimulus();
    int         fd;
    int         got;
    string      line;
    logic [7:0] f [12];
    fd = $fopen("bench/ram512k_stimulus.txt", "r");
    if (fd == 0) begin
      $display("CHECKS FAILED");
      $fatal(1, "cannot open the stimulus file bench/ram512k_stimulus.txt");
    end
    while (!$feof(fd)) begin
      got = $fgets(line, fd);
      // Comment and blank lines hold no transaction
      if (got > 1 && line.getc(0) != "#") begin
        got = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
                      f[0], f[1], f[2], f[3], f[4], f[5],
                      f[6], f[7], f[8], f[9], f[10], f[11]);
        if (got != 12 || line_count == max_lines) begin
          $display("CHECKS FAILED");
          $fatal(1, "stimulus line %0d is malformed or the file is too long", line_count);
        end
        for (int k = 0; k < 12; k++) begin
          stim[line_count][k] = f[k];
        end
        line_count++;
      end
    end
    $fclose(fd);
  endtask

  // Expected value ff means the column is not checked
  task automatic check_value(input string name, input logic [7:0] actual,
                             input logic [7:0] expected);
    if (expected != 8'hff && actual !== expected) begin
      $display("error at time %0t: %s is %0h, expected %0h", $time, name, actual, expected);
      $display("CHECKS FAILED");
      $fatal(1, "output mismatch on %s", name);
    end
  endtask

  // The WR pull only exists in the first sampled cycle
  task automatic check_outputs(input int i, input logic first);
    logic [7:0] wr_exp;
    wr_exp = (first || stim[i][11] == 8'hff) ? stim[i][11] : 8'h00;
    check_value("ramcs_b", {7'b0, ramcs_b}, stim[i][6]);
    check_value("ramadrhi", {3'b0, ramadrhi}, stim[i][7]);
    check_value("ramdis_oe", {7'b0, ramdis_oe}, stim[i][8]);
    check_value("adr15_oe", {7'b0, adr15_oe}, stim[i][9]);
    check_value("rd_oe", {7'b0, rd_oe}, stim[i][10]);
    check_value("wr_oe", {7'b0, wr_oe}, wr_exp);
    // The SRAM high address pins are released only while in reset
    check_value("ramadrhi_oe", {7'b0, ramadrhi_oe}, {7'b0, reset_b_w});
    // SRAM OE and WE follow the RAMRD and WR strobes of the bus
    check_value("ramoe_b", {7'b0, ramoe_b}, {7'b0, ramrd_b});
    check_value("ramwe_b", {7'b0, ramwe_b}, {7'b0, wr_b});
    // A pulled pin carries its active level whenever it is enabled
    if (stim[i][8] == 8'h01) begin
      check_value("ramdis", {7'b0, ramdis}, 8'h01);
    end
    if (stim[i][9] == 8'h01) begin
      check_value("adr15_drive", {7'b0, adr15_drive}, 8'h01);
    end
    if (stim[i][10] == 8'h01) begin
      check_value("rd_drive", {7'b0, rd_drive}, 8'h00);
    end
    if (wr_exp == 8'h01) begin
      check_value("wr_drive", {7'b0, wr_drive}, 8'h00);
    end
  endtask

  task automatic drive_bus(input int i);
    dip   = stim[i][1][3:0];
    adr15 = stim[i][2][0];
    adr14 = stim[i][3][0];
    adr8  = stim[i][4][0];
    data  = stim[i][5];
  endtask

  // Outputs are checked on the last falling edge of the reset
  task automatic apply_reset(input int i);
    @(negedge clk);
    drive_bus(i);
    reset_b_w = 1'b0;
    repeat (reset_cycles) @(negedge clk);
    check_outputs(i, 1'b1);
    reset_b_w = 1'b1;
  endtask

  task automatic io_write(input int i);
    @(negedge clk);
    drive_bus(i);
    iorq_b = 1'b0;
    wr_b   = 1'b0;
    @(negedge clk);
    check_outputs(i, 1'b1);
    iorq_b = 1'b1;
    wr_b   = 1'b1;
  endtask

  // MREQ falls mid-cycle, the next rising edge classifies it and
  // the outputs are checked after that edge and after the one after
  task automatic mem_cycle(input int i);
    logic [7:0] kind;
    kind = stim[i][0];
    @(negedge clk);
    drive_bus(i);
    mreq_b  = 1'b0;
    rfsh_b  = (kind != 8'h04);
    rd_b    = (kind != 8'h02);
    ramrd_b = (kind != 8'h02);
    @(negedge clk);
    check_outputs(i, 1'b1);
    // The CPU drops WR later in the write cycle
    if (kind == 8'h03) begin
      wr_b = 1'b0;
    end
    @(negedge clk);
    check_outputs(i, 1'b0);
    mreq_b  = 1'b1;
    rfsh_b  = 1'b1;
    rd_b    = 1'b1;
    wr_b    = 1'b1;
    ramrd_b = 1'b1;
    // One idle clock lets the cycle state return to idle
    @(negedge clk);
  endtask

  initial begin
    clk       = 1'b0;
    reset_b_w = 1'b0;
    adr15     = 1'b0;
    adr14     = 1'b0;
    adr8      = 1'b0;
    iorq_b    = 1'b1;
    mreq_b    = 1'b1;
    rfsh_b    = 1'b1;
    m1_b      = 1'b1;
    rd_b      = 1'b1;
    wr_b      = 1'b1;
    ramrd_b   = 1'b1;
    data      = 8'h00;
    dip       = 4'h0;
    load_stimulus();
    if (line_count == 0) begin
      $display("CHECKS FAILED");
      $fatal(1, "the stimulus file holds no transactions");
    end
    cycle_limit = 20 * line_count;
    for (int i = 0; i < line_count; i++) begin
      case (stim[i][0])
        8'h00: apply_reset(i);
        8'h01: io_write(i);
        8'h02, 8'h03, 8'h04: mem_cycle(i);
        default: begin
          $display("CHECKS FAILED");
          $fatal(1, "unknown transaction kind %0h on stimulus line %0d", stim[i][0], i);
        end
      endcase
    end
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: ram512k_ctrl.f
rtl/cpc_ram_pkg.sv
rtl/bank_reg_decode.sv
rtl/mem_cycle_track.sv
rtl/block_map.sv
rtl/ram_strobe_drive.sv
rtl/ram512k_ctrl.sv
bench/ram512k_ctrl_sva.sv
bench/ram512k_ctrl_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the 512K RAM expansion controller testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module ram512k_ctrl_tb -f ram512k_ctrl.f
# The stimulus path in the testbench is relative to the project root
./obj_dir/Vram512k_ctrl_tb

// File: bench/ram512k_stimulus.txt
# kind dip adr15 adr14 adr8 data, then ramcs_b ramadrhi ramdis_oe adr15_oe rd_oe wr_oe (hex)
# kind 0 reset, 1 io write, 2 mem read, 3 mem write, 4 refresh; ff is a column not checked
# No options, port 0x7Fxx, every scheme in turn
0 0 0 0 0 00 1 ff 0 0 0 0
2 0 1 1 0 00 1 ff 0 0 0 0
3 0 0 1 0 00 1 ff 0 0 0 0
1 0 0 1 1 e8 1 ff ff ff ff ff
2 0 1 1 0 00 1 ff 0 0 0 0
1 0 0 1 1 e9 1 ff ff ff ff ff
2 0 1 1 0 00 0 17 1 0 0 0
2 0 1 0 0 00 1 ff 0 0 0 0
1 0 0 1 1 d2 1 ff ff ff ff ff
3 0 0 0 0 00 0 08 1 0 0 0
2 0 1 0 0 00 0 0a 1 0 0 0
1 0 0 1 1 f4 1 ff ff ff ff ff
2 0 0 1 0 00 0 18 1 0 0 0
2 0 0 0 0 00 1 ff 0 0 0 0
1 0 0 1 1 cd 1 ff ff ff ff ff
2 0 0 1 0 00 0 05 1 0 0 0
1 0 0 1 1 fe 1 ff ff ff ff ff
2 0 0 1 0 00 0 1e 1 0 0 0
1 0 0 1 1 c7 1 ff ff ff ff ff
3 0 0 1 0 00 0 03 1 0 0 0
1 0 0 1 0 e1 1 ff ff ff ff ff
2 0 0 1 0 00 0 03 1 0 0 0
2 0 1 1 0 00 1 ff 0 0 0 0
1 0 0 1 1 db 1 ff ff ff ff ff
2 0 1 1 0 00 0 0f 1 0 0 0
# Overdrive only, C3 then all blocks
0 2 0 0 0 00 1 ff 0 0 0 0
1 2 0 1 1 cb 1 ff ff ff ff ff
2 2 0 1 0 00 1 ff 0 1 0 0
3 2 1 1 0 00 0 07 1 1 1 1
2 2 1 0 0 00 1 ff 0 0 0 0
1 2 0 1 1 e2 1 ff ff ff ff ff
3 2 1 0 0 00 0 12 1 0 1 1
2 2 0 0 0 00 0 10 1 0 0 0
# Partial shadow with shadow bank 7
0 9 0 0 0 00 1 ff 0 0 0 0
1 9 0 1 1 d1 1 ff ff ff ff ff
3 9 0 0 0 00 0 1c 1 0 0 0
2 9 0 0 0 00 1 ff 0 0 0 0
3 9 1 1 0 00 0 0b 1 0 1 1
1 9 0 1 1 f9 1 ff ff ff ff ff
2 9 1 1 0 00 0 17 1 0 0 0
1 9 0 1 1 d3 1 ff ff ff ff ff
2 9 0 1 0 00 0 1f 1 0 0 0
3 9 0 1 0 00 0 1f 1 1 0 0
3 9 1 1 0 00 0 0b 1 1 1 1
2 9 1 0 0 00 1 ff 0 0 0 0
# Full shadow on port 0x7Exx with shadow bank 3
0 7 0 0 0 00 1 ff 0 0 0 0
2 7 1 0 0 00 0 0e 1 0 0 0
4 7 0 0 0 00 1 ff 1 0 0 0
1 7 0 1 1 e9 1 ff ff ff ff ff
2 7 1 1 0 00 0 0f 1 0 0 0
1 7 0 1 0 f2 1 ff ff ff ff ff
2 7 1 1 0 00 0 1b 1 0 0 0
3 7 0 1 0 00 0 19 1 0 1 1
